// File: Bender.yml
package:
  name: mandel

sources:
  - include_dirs:
      - hw
    files:
      - hw/mandel_pkg.sv
      - hw/mandel_job_if.sv
      - hw/mandel_iter_core.sv
      - hw/mandel_pixel_scan.sv
      - hw/mandel_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/mandel_checker.sv
      - dv/tb_mandel.sv

// File: dv/mandel_checker.sv
`timescale 1ns/1ns
`include "mandel_config.svh"

// watches the pixel outputs of the DUT and compares each pixel with
// the next expected entry that the testbench pushes in raster order

module mandel_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pix_vld,
    input  logic [`MANDEL_COL_W-1:0] pix_col,
    input  logic [`MANDEL_ROW_W-1:0] pix_row,
    input  logic [`MANDEL_ITER_W-1:0] pix_iter,
    input  logic                     busy,
    input  logic                     frame_done
);

    // expected pixels in arrival order
    int exp_col_q[$];
    int exp_row_q[$];
    int exp_iter_q[$];
    bit exp_last_q[$];   // last pixel of its frame

    int value_errors = 0;
    int other_errors = 0;
    bit expect_idle  = 1'b1;  // outputs stay quiet while no frame runs
    bit done_seen    = 1'b0;  // frame_done on the previous falling edge

    // ------------------------------------------------------------------
    // calls from the testbench
    // ------------------------------------------------------------------
    task automatic push_expect(input int col, input int row, input int iter,
                               input bit last);
        exp_col_q.push_back(col);
        exp_row_q.push_back(row);
        exp_iter_q.push_back(iter);
        exp_last_q.push_back(last);
    endtask

    task automatic set_idle(input bit idle);
        expect_idle = idle;
    endtask

    function automatic int pending();
        return exp_col_q.size();
    endfunction

    task automatic compare_value(input string name, input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            $display("error at %0t ns: %s expected %0d got %0d",
                     $time, name, exp_val, act_val);
            value_errors++;
        end
    endtask

    // busy level right now
    task automatic expect_busy(input bit level);
        compare_value("busy", int'(level), int'(busy));
    endtask

    // ------------------------------------------------------------------
    // outputs sampled mid-cycle on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        int  e_col;
        int  e_row;
        int  e_iter;
        bit  e_last;
        if (rst) begin
            done_seen = 1'b0;
        end else begin
            if (expect_idle) begin
                compare_value("pix_vld", 0, int'(pix_vld));
                compare_value("busy", 0, int'(busy));
                compare_value("frame_done", 0, int'(frame_done));
            end
            if (done_seen) begin
                compare_value("busy", 0, int'(busy));  // drops right after last pixel
            end
            done_seen = frame_done;
            if (pix_vld) begin
                compare_value("busy", 1, int'(busy));
                if (exp_col_q.size() == 0) begin
                    $display("extra pixel at %0t ns, col %0d row %0d, none expected",
                             $time, pix_col, pix_row);
                    other_errors++;
                end else begin
                    e_col  = exp_col_q.pop_front();
                    e_row  = exp_row_q.pop_front();
                    e_iter = exp_iter_q.pop_front();
                    e_last = exp_last_q.pop_front();
                    compare_value("pix_col", e_col, int'(pix_col));
                    compare_value("pix_row", e_row, int'(pix_row));
                    compare_value("pix_iter", e_iter, int'(pix_iter));
                    compare_value("frame_done", int'(e_last), int'(frame_done));
                end
            end else if (frame_done) begin
                $display("frame_done at %0t ns came without a pixel", $time);
                other_errors++;
            end
        end
    end

endmodule

// File: dv/mandel_golden.txt
# frame lines: frame re_start im_start re_step im_step (q4.12, hex)
# pixel lines: col row count (decimal, raster order, 24 per frame)
frame e000 f000 1000 1000
0 0 1
1 0 3
2 0 100
3 0 2
4 0 1
5 0 1
0 1 1
1 1 100
2 1 100
3 1 2
4 1 1
5 1 1
0 2 1
1 2 3
2 2 100
3 2 2
4 2 1
5 2 1
0 3 1
1 3 1
2 3 1
3 3 1
4 3 1
5 3 1
frame f800 d800 0400 2800
0 0 1
1 0 1
2 0 1
3 0 1
4 0 1
5 0 1
0 1 100
1 1 100
2 1 100
3 1 100
4 1 5
5 1 3
0 2 1
1 2 1
2 2 1
3 2 1
4 2 1
5 2 1
0 3 1
1 3 1
2 3 1
3 3 1
4 3 1
5 3 1

// File: dv/tb_mandel.sv
`timescale 1ns/1ns
`include "mandel_config.svh"

module tb_mandel;

    localparam int PIX_PER_FRAME = `MANDEL_COLS * `MANDEL_ROWS;
    localparam int FRAME_TIMEOUT = 20000;  // a frame needs under 5000 cycles
    localparam int BUSY_TIMEOUT  = 10;

    logic               clk = 1'b0;
    logic               rst;
    logic               start;
    mandel_pkg::fixed_t re_start;
    mandel_pkg::fixed_t im_start;
    mandel_pkg::fixed_t re_step;
    mandel_pkg::fixed_t im_step;

    logic               pix_vld;
    mandel_pkg::col_t   pix_col;
    mandel_pkg::row_t   pix_row;
    mandel_pkg::iter_t  pix_iter;
    logic               busy;
    logic               frame_done;

    int tb_errors = 0;
    bit timed_out = 1'b0;

    always #5 clk = ~clk;  // 10 ns

    mandel_top uut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .re_start   (re_start),
        .im_start   (im_start),
        .re_step    (re_step),
        .im_step    (im_step),
        .pix_vld    (pix_vld),
        .pix_col    (pix_col),
        .pix_row    (pix_row),
        .pix_iter   (pix_iter),
        .busy       (busy),
        .frame_done (frame_done)
    );

    mandel_checker chk (
        .clk        (clk),
        .rst        (rst),
        .pix_vld    (pix_vld),
        .pix_col    (pix_col),
        .pix_row    (pix_row),
        .pix_iter   (pix_iter),
        .busy       (busy),
        .frame_done (frame_done)
    );

    // ------------------------------------------------------------------
    // one frame with start pulse, optional start while busy and wait for end
    // ------------------------------------------------------------------
    task automatic run_frame(input mandel_pkg::fixed_t rs, input mandel_pkg::fixed_t is,
                             input mandel_pkg::fixed_t rd, input mandel_pkg::fixed_t id,
                             input bit poke_busy);
        int cyc;
        @(negedge clk);
        re_start = rs;
        im_start = is;
        re_step  = rd;
        im_step  = id;
        start    = 1'b1;
        chk.set_idle(1'b0);
        @(negedge clk);
        start = 1'b0;

        if (poke_busy) begin
            repeat (4) @(negedge clk);
            chk.expect_busy(1'b1);  // start below lands mid-frame
            re_start = 16'h1000;  // junk set-up that must be ignored
            im_start = 16'h1000;
            re_step  = 16'h0100;
            im_step  = 16'h0100;
            start    = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end

        cyc = 0;
        while (frame_done !== 1'b1 && cyc < FRAME_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (frame_done !== 1'b1) begin
            $display("timeout, no frame_done within %0d cycles", FRAME_TIMEOUT);
            tb_errors++;
            timed_out = 1'b1;
        end else begin
            cyc = 0;
            while (busy !== 1'b0 && cyc < BUSY_TIMEOUT) begin
                @(negedge clk);
                cyc++;
            end
            if (busy !== 1'b0) begin
                $display("busy stayed high after frame_done");
                tb_errors++;
            end
            chk.set_idle(1'b1);
            repeat (20) @(negedge clk);  // window for stray pixels
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int                 fd;
        int                 n;
        int                 c;
        int                 r;
        int                 it;
        int                 px;
        int                 frame_no;
        int                 total;
        string              line;
        mandel_pkg::fixed_t h0;
        mandel_pkg::fixed_t h1;
        mandel_pkg::fixed_t h2;
        mandel_pkg::fixed_t h3;

        rst      = 1'b1;
        start    = 1'b0;
        re_start = '0;
        im_start = '0;
        re_step  = '0;
        im_step  = '0;
        px       = 0;
        frame_no = 0;
        h0 = '0;
        h1 = '0;
        h2 = '0;
        h3 = '0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);  // quiet outputs before any start

        fd = $fopen("dv/mandel_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/mandel_golden.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#") begin
                    if (line[0] == "f") begin
                        n  = $sscanf(line, "frame %h %h %h %h", h0, h1, h2, h3);
                        px = 0;
                        if (n != 4) begin
                            $display("bad frame line in golden file");
                            tb_errors++;
                        end
                    end else if ($sscanf(line, "%d %d %d", c, r, it) == 3) begin
                        px++;
                        chk.push_expect(c, r, it, px == PIX_PER_FRAME);
                        if (px == PIX_PER_FRAME) begin
                            run_frame(h0, h1, h2, h3, frame_no == 1);
                            frame_no++;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        if (frame_no != 2) begin
            $display("only %0d of 2 frames were run", frame_no);
            tb_errors++;
        end
        if (chk.pending() != 0) begin
            $display("%0d expected pixels never arrived", chk.pending());
            tb_errors++;
        end

        total = chk.value_errors + chk.other_errors + tb_errors;
        $display("errors: value %0d, other %0d", chk.value_errors,
                 chk.other_errors + tb_errors);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: hw/mandel_config.svh
`ifndef MANDEL_CONFIG_SVH
`define MANDEL_CONFIG_SVH

// fixed point format, signed q4.12
`define MANDEL_WIDTH      16   // bits per number
`define MANDEL_INT_BITS   4    // integer bits incl sign

// escape-time loop
`define MANDEL_MAX_ITER   100
`define MANDEL_ITER_W     7    // holds 0..MAX_ITER
// squared magnitude limit, 4.0 in q4.12 (no sqrt taken)
`define MANDEL_THRESHOLD  (4 << (`MANDEL_WIDTH - `MANDEL_INT_BITS))

// frame geometry
`define MANDEL_COLS       6
`define MANDEL_ROWS       4
`define MANDEL_COL_W      3
`define MANDEL_ROW_W      2

`endif

// File: hw/mandel_iter_core.sv
`timescale 1ns/1ns
`include "mandel_config.svh"

// escape-time iteration for a single point c = rc + ic*i
//
// z(k+1) = z(k)^2 + c, with z = re + im*i
//   re(k+1) = re^2 - im^2 + rc
//   im(k+1) = 2*re*im + ic
//   m(k)    = re^2 + im^2      compared against 4.0
//
// each iteration runs over two cycles
//   multiply   full 32 bit products re*re, im*im, re*im
//   add/test   cut products to q4.12, form z(k+1), test m(k)
//
// a 16x16 product of two q4.12 values is q8.24. keeping bits 27..12
// brings it back to q4.12; the upper integer bits are dropped, so big
// values wrap instead of clipping
//
// z(0) is zero so z(1) is just c; req loads c straight into z, and the
// first multiply stage already works on z(1). test of m(k) then falls
// on cycle 2k after req and vld on cycle 2k+1

module mandel_iter_core (
    input  logic       clk,
    input  logic       rst,
    mandel_job_if.core job
);

    localparam int W    = `MANDEL_WIDTH;
    localparam int FRAC = `MANDEL_WIDTH - `MANDEL_INT_BITS;  // fraction bits

    localparam mandel_pkg::iter_t ITER_LIMIT = mandel_pkg::iter_t'(`MANDEL_MAX_ITER);
    localparam logic [W-1:0]      THRESHOLD  = `MANDEL_THRESHOLD;

    // q8.24 product back to q4.12, middle field only
    function automatic mandel_pkg::fixed_t trunc_prod(input logic signed [2*W-1:0] p);
        return p[FRAC +: W];
    endfunction

    // ------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------
    logic                  mul_stg;  // multiply stage this cycle
    logic                  add_stg;  // add/test stage this cycle
    logic                  done;     // escaped or out of iterations
    mandel_pkg::iter_t     count;    // = k during add stage of z(k)

    mandel_pkg::fixed_t    z_re;     // current z(k)
    mandel_pkg::fixed_t    z_im;

    logic signed [2*W-1:0] rr_q;     // re*re
    logic signed [2*W-1:0] ii_q;     // im*im
    logic signed [2*W-1:0] ri_q;     // re*im

    mandel_pkg::fixed_t    rr_t;     // truncated products
    mandel_pkg::fixed_t    ii_t;
    mandel_pkg::fixed_t    ri_t;
    mandel_pkg::fixed_t    nxt_re;   // z(k+1)
    mandel_pkg::fixed_t    nxt_im;
    logic [W-1:0]          mag;      // m(k), unsigned view

    // ------------------------------------------------------------------
    // stage control
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_stg <= 1'b0;
            add_stg <= 1'b0;
            job.vld <= 1'b0;
        end else begin
            // loop back to multiply until the point is finished
            mul_stg <= job.req | (add_stg & ~done);
            add_stg <= mul_stg;
            job.vld <= add_stg & done;  // single pulse, loop stops here
        end
    end

    // iteration counter, one step per multiply stage
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (job.req) begin
            count <= '0;
        end else if (mul_stg) begin
            count <= count + 1'b1;
        end
    end

    assign job.iter = count;  // held while loop is idle

    // ------------------------------------------------------------------
    // multiply stage
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (job.req) begin
            z_re <= job.rc;  // z(1) = c
            z_im <= job.ic;
        end else if (add_stg) begin
            z_re <= nxt_re;
            z_im <= nxt_im;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_stg) begin
            rr_q <= z_re * z_re;
            ii_q <= z_im * z_im;
            ri_q <= z_re * z_im;
        end
    end

    // ------------------------------------------------------------------
    // add / test stage
    // ------------------------------------------------------------------
    always_comb begin
        rr_t   = trunc_prod(rr_q);
        ii_t   = trunc_prod(ii_q);
        ri_t   = trunc_prod(ri_q);

        // sums wrap at 16 bits
        nxt_re = rr_t - ii_t + job.rc;
        nxt_im = (ri_t <<< 1) + job.ic;  // 2*re*im
        mag    = rr_t + ii_t;

        // count hits the limit only after k = 99 failed to escape
        done   = (mag >= THRESHOLD) | (count == ITER_LIMIT);
    end

endmodule

// File: hw/mandel_job_if.sv
`timescale 1ns/1ns

// one point job, scanner -> core, and its escape count back
//
// scanner pulses req for one cycle with c on rc/ic, only when the
// previous job has finished; rc/ic stay put until vld comes back
// since the core adds c again on every iteration
interface mandel_job_if;

    logic               req;   // 1-cycle job start
    mandel_pkg::fixed_t rc;    // real part of c
    mandel_pkg::fixed_t ic;    // imaginary part of c
    logic               vld;   // 1-cycle job end
    mandel_pkg::iter_t  iter;  // count, good while vld

    // pixel scanner side
    modport scanner (
        output req,
        output rc,
        output ic,
        input  vld,
        input  iter
    );

    // iteration core side
    modport core (
        input  req,
        input  rc,
        input  ic,
        output vld,
        output iter
    );

endinterface

// File: hw/mandel_pixel_scan.sv
`timescale 1ns/1ns
`include "mandel_config.svh"

// raster scanner for one frame
//
// walks col 0..COLS-1 inside row 0..ROWS-1, keeps c of the current
// pixel in two accumulators and hands it to the core, one job at a time
//   re = re_start + col*re_step   (reloaded at each new row)
//   im = im_start + row*im_step
//
// timing
//   start           -> req next cycle, busy rises with it
//   core vld        -> pix_vld next cycle, next req in that same cycle
//   last pixel      -> frame_done with pix_vld, busy drops after it

module mandel_pixel_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,     // 1-cycle, ignored while busy
    input  mandel_pkg::fixed_t re_start,  // c of pixel (0,0)
    input  mandel_pkg::fixed_t im_start,
    input  mandel_pkg::fixed_t re_step,   // per column
    input  mandel_pkg::fixed_t im_step,   // per row
    mandel_job_if.scanner      job,
    output logic               pix_vld,
    output mandel_pkg::col_t   pix_col,
    output mandel_pkg::row_t   pix_row,
    output mandel_pkg::iter_t  pix_iter,
    output logic               busy,
    output logic               frame_done
);

    localparam mandel_pkg::col_t LAST_COL = mandel_pkg::col_t'(`MANDEL_COLS - 1);
    localparam mandel_pkg::row_t LAST_ROW = mandel_pkg::row_t'(`MANDEL_ROWS - 1);

    // ------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------
    mandel_pkg::col_t   col;     // pixel of the job in flight
    mandel_pkg::row_t   row;
    mandel_pkg::fixed_t re_acc;  // c of that pixel
    mandel_pkg::fixed_t im_acc;
    mandel_pkg::fixed_t re_org;  // sampled on start
    mandel_pkg::fixed_t re_inc;
    mandel_pkg::fixed_t im_inc;

    logic launch;    // accepted start
    logic res_in;    // core result for current pixel
    logic last_col;
    logic last_pix;

    assign launch   = start & ~busy;
    assign res_in   = busy & job.vld;
    assign last_col = (col == LAST_COL);
    assign last_pix = last_col & (row == LAST_ROW);

    // c stays on the bus until the next pixel is set up
    assign job.rc = re_acc;
    assign job.ic = im_acc;

    // ------------------------------------------------------------------
    // frame control
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            job.req    <= 1'b0;
            pix_vld    <= 1'b0;
            frame_done <= 1'b0;
            col        <= '0;
            row        <= '0;
        end else begin
            pix_vld    <= res_in;
            frame_done <= res_in & last_pix;
            job.req    <= launch | (res_in & ~last_pix);  // next pixel right away

            if (launch) begin
                busy <= 1'b1;
                col  <= '0;
                row  <= '0;
            end else if (frame_done) begin
                busy <= 1'b0;  // low the cycle after the last pixel
            end

            // step to next pixel, raster order
            if (res_in) begin
                if (last_col) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // coordinate accumulators and result capture
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (launch) begin
            re_org <= re_start;
            re_inc <= re_step;
            im_inc <= im_step;
            re_acc <= re_start;
            im_acc <= im_start;
        end else if (res_in) begin
            if (last_col) begin
                re_acc <= re_org;           // back to left edge
                im_acc <= im_acc + im_inc;  // one row down
            end else begin
                re_acc <= re_acc + re_inc;
            end
        end

        // tag count with the pixel it belongs to
        if (res_in) begin
            pix_col  <= col;
            pix_row  <= row;
            pix_iter <= job.iter;
        end
    end

endmodule

// File: hw/mandel_pkg.sv
`include "mandel_config.svh"

// shared types of the mandelbrot renderer
//
// numbers are signed q4.12
//   bit 15      sign
//   bits 14..12 integer part
//   bits 11..0  fraction
// so the range is -8.0 up to just under +8.0, lsb = 1/4096

package mandel_pkg;

    // one real or imaginary coordinate
    typedef logic signed [`MANDEL_WIDTH-1:0] fixed_t;

    // escape count, 1..MAX_ITER
    typedef logic [`MANDEL_ITER_W-1:0] iter_t;

    // pixel position in the frame
    typedef logic [`MANDEL_COL_W-1:0] col_t;   // 0 .. COLS-1
    typedef logic [`MANDEL_ROW_W-1:0] row_t;   // 0 .. ROWS-1

endpackage

// File: hw/mandel_top.sv
`timescale 1ns/1ns

// mandelbrot frame renderer
//
// scanner walks the frame and feeds one point at a time into the
// escape-time core over the job interface; results leave as one
// pix_vld pulse per pixel with column, row and count
//
//   start ---> pixel_scan ---job---> iter_core
//                  ^                     |
//                  +------- count -------+
//                  |
//                  +--> pix_* / busy / frame_done

module mandel_top (
    input  logic               clk,
    input  logic               rst,

    // frame set-up, sampled on start
    input  logic               start,
    input  mandel_pkg::fixed_t re_start,
    input  mandel_pkg::fixed_t im_start,
    input  mandel_pkg::fixed_t re_step,
    input  mandel_pkg::fixed_t im_step,

    // pixel results, no back-pressure
    output logic               pix_vld,
    output mandel_pkg::col_t   pix_col,
    output mandel_pkg::row_t   pix_row,
    output mandel_pkg::iter_t  pix_iter,
    output logic               busy,
    output logic               frame_done
);

    // scanner <-> core job channel
    mandel_job_if job ();

    // ------------------------------------------------------------------
    // raster scanner
    // ------------------------------------------------------------------
    mandel_pixel_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .re_start   (re_start),
        .im_start   (im_start),
        .re_step    (re_step),
        .im_step    (im_step),
        .job        (job.scanner),
        .pix_vld    (pix_vld),
        .pix_col    (pix_col),
        .pix_row    (pix_row),
        .pix_iter   (pix_iter),
        .busy       (busy),
        .frame_done (frame_done)
    );

    // ------------------------------------------------------------------
    // escape-time core
    // ------------------------------------------------------------------
    mandel_iter_core u_core (
        .clk (clk),
        .rst (rst),
        .job (job.core)
    );

endmodule

// File: tb.f
+incdir+hw
hw/mandel_pkg.sv
hw/mandel_job_if.sv
hw/mandel_iter_core.sv
hw/mandel_pixel_scan.sv
hw/mandel_top.sv
dv/mandel_checker.sv
dv/tb_mandel.sv
